/* msp430Periph.f */
+incdir+.
msp430PeriphPkg.sv
axiLiteRegBridge.sv
digitalPort.sv
timerA.sv
interruptUnit.sv
msp430Periph.sv
msp430Periph_asserts.sv
msp430Periph_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the msp430Periph testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module msp430Periph_tb \
    -f msp430Periph.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmsp430Periph_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
    exit 0
fi
exit 1

/* msp430Periph_tb.sv */
`timescale 1ns/1ps
`include "msp430Periph_macros.svh"

module msp430Periph_tb;

    localparam int WAIT_LIMIT = 50;

    logic                      SysClock;
    logic                      reset;
    msp430PeriphPkg::regAddr   awaddr;
    logic                      awvalid;
    logic                      awready;
    msp430PeriphPkg::regData   wdata;
    logic [1:0]                wstrb;
    logic                      wvalid;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      bready;
    msp430PeriphPkg::regAddr   araddr;
    logic                      arvalid;
    logic                      arready;
    msp430PeriphPkg::regData   rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
    logic                      rready;
    msp430PeriphPkg::portBits  pinIn;
    msp430PeriphPkg::portBits  pinOut;
    msp430PeriphPkg::portBits  pinOutEnable;
    logic                      irq;
    msp430PeriphPkg::irqVector irqVector;
    logic                      irqAck;

    int errors;

    msp430Periph uut (
        .SysClock(SysClock), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .pinIn(pinIn), .pinOut(pinOut), .pinOutEnable(pinOutEnable),
        .irq(irq), .irqVector(irqVector), .irqAck(irqAck)
    );

    bind msp430Periph msp430Periph_assertions checks (
        .SysClock(SysClock), .reset(reset),
        .awready(awready), .wready(wready), .arready(arready),
        .bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready),
        .rdata(rdata), .pinOutEnable(pinOutEnable),
        .irq(irq), .irqVector(irqVector), .irqAck(irqAck),
        .ccr0Irq(ccr0Irq), .ccrIrq(ccrIrq), .portIrq(portIrq)
    );

    always #10 SysClock = ~SysClock;

    task automatic endRun();
        errors += uut.checks.failures;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic timeoutFail(input string what);
        errors++;
        $display("Timed out at %0t ns while waiting for %s", $time, what);
    endtask

    task automatic checkValue(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("Mismatch at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic writeReg(input msp430PeriphPkg::regAddr addr,
                            input msp430PeriphPkg::regData data);
        int count;
        @(posedge SysClock);
        awaddr  <= addr;
        wdata   <= data;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        count = 0;
        do begin
            @(negedge SysClock);
            count++;
        end while (!awready && count < WAIT_LIMIT);
        if (!awready) timeoutFail("awready");
        checkValue("wready", 16'd1, 16'(wready));
        @(posedge SysClock);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        count = 0;
        do begin
            @(negedge SysClock);
            count++;
        end while (!bvalid && count < WAIT_LIMIT);
        if (!bvalid) timeoutFail("bvalid");
        checkValue("bresp", 16'd0, 16'(bresp));
        // response sits one cycle before bready
        @(posedge SysClock);
        bready <= 1'b1;
        @(posedge SysClock);
        bready <= 1'b0;
    endtask

    task automatic readReg(input msp430PeriphPkg::regAddr addr,
                           output msp430PeriphPkg::regData data);
        int count;
        @(posedge SysClock);
        araddr  <= addr;
        arvalid <= 1'b1;
        count = 0;
        do begin
            @(negedge SysClock);
            count++;
        end while (!arready && count < WAIT_LIMIT);
        if (!arready) timeoutFail("arready");
        @(posedge SysClock);
        arvalid <= 1'b0;
        count = 0;
        do begin
            @(negedge SysClock);
            count++;
        end while (!rvalid && count < WAIT_LIMIT);
        if (!rvalid) timeoutFail("rvalid");
        data = rdata;
        checkValue("rresp", 16'd0, 16'(rresp));
        @(posedge SysClock);
        rready <= 1'b1;
        @(posedge SysClock);
        rready <= 1'b0;
    endtask

    task automatic waitIrqLevel(input logic level);
        int count;
        count = 0;
        do begin
            @(negedge SysClock);
            count++;
        end while (irq !== level && count < WAIT_LIMIT);
        if (irq !== level) timeoutFail("irq level change");
    endtask

    task automatic waitVector(input msp430PeriphPkg::irqVector vec, input int limit);
        int count;
        count = 0;
        do begin
            @(negedge SysClock);
            count++;
        end while ((irq !== 1'b1 || irqVector !== vec) && count < limit);
        if (irq !== 1'b1 || irqVector !== vec) timeoutFail("interrupt vector");
    endtask

    task automatic writeReadBack(input string name, input msp430PeriphPkg::regAddr addr,
                                 input msp430PeriphPkg::regData data);
        msp430PeriphPkg::regData value;
        writeReg(addr, data);
        readReg(addr, value);
        checkValue(name, data, value);
    endtask

    initial begin
        msp430PeriphPkg::regData  value;
        msp430PeriphPkg::regData  poutValue;
        msp430PeriphPkg::regData  pdirValue;
        msp430PeriphPkg::portBits pinValue;
        msp430PeriphPkg::portBits pinMask;
        int period;
        int high;
        int highCount;

        errors = 0;
        void'($urandom(32'h1bb4ef95));
        SysClock = 1'b0;
        reset    = 1'b1;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = 2'b11;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        pinIn    = '0;
        irqAck   = 1'b0;
        repeat (2) @(posedge SysClock);
        reset <= 1'b0;

        // register access
        poutValue = 16'($urandom);
        pdirValue = 16'($urandom);
        writeReadBack("POUT", `PORT_BASE + `POUT_OFS, poutValue);
        writeReadBack("PDIR", `PORT_BASE + `PDIR_OFS, pdirValue);
        writeReadBack("PIE", `PORT_BASE + `PIE_OFS, 16'($urandom));
        writeReadBack("TACCR1", `TIMER_BASE + `TACCR1_OFS, 16'($urandom));
        readReg(16'h0100, value);
        checkValue("unmapped rdata", 16'd0, value);
        writeReg(`PORT_BASE + `PIE_OFS, 16'd0);

        // port pins with PSEL clear
        @(negedge SysClock);
        checkValue("pinOut", poutValue, pinOut);
        checkValue("pinOutEnable", pdirValue, pinOutEnable);
        pinValue = 16'($urandom);
        @(posedge SysClock);
        pinIn <= pinValue;
        repeat (4) @(posedge SysClock);
        readReg(`PORT_BASE + `PIN_OFS, value);
        checkValue("PIN", pinValue, value);

        // timer pwm on pin 0
        period = 8 + ($urandom % 16);
        high   = 1 + ($urandom % period);
        writeReg(`TIMER_BASE + `TACCR0_OFS, 16'(period));
        writeReg(`TIMER_BASE + `TACCR1_OFS, 16'(high));
        writeReg(`PORT_BASE + `PSEL_OFS, 16'd1);
        writeReg(`TIMER_BASE + `TACTL_OFS, (16'd1 << `TA_RUN) | (16'd1 << `TA_CLEAR));
        repeat ($urandom % period) @(negedge SysClock);
        checkValue("pinOutEnable[0]", 16'd1, 16'(pinOutEnable[0]));
        highCount = 0;
        repeat (period + 1) begin
            @(negedge SysClock);
            if (pinOut[0]) highCount++;
        end
        checkValue("pwm high cycles", 16'(high), 16'(highCount));

        // port edge interrupt
        pinMask = 16'd1 << (2 + ($urandom % 14));
        @(posedge SysClock);
        pinIn <= pinIn & ~pinMask;
        repeat (4) @(posedge SysClock);
        writeReg(`PORT_BASE + `PIFG_OFS, 16'd0);
        writeReg(`PORT_BASE + `PIE_OFS, pinMask);
        @(posedge SysClock);
        pinIn <= pinIn | pinMask;
        waitIrqLevel(1'b1);
        checkValue("irqVector", 16'(`VEC_PORT), 16'(irqVector));
        writeReg(`PORT_BASE + `PIFG_OFS, 16'd0);
        waitIrqLevel(1'b0);

        // priority and acknowledge
        // long period keeps the next wrap far away
        writeReg(`TIMER_BASE + `TACCR0_OFS, 16'd200);
        @(posedge SysClock);
        pinIn <= pinIn & ~pinMask;
        repeat (4) @(posedge SysClock);
        pinIn <= pinIn | pinMask;
        waitVector(`VEC_PORT, WAIT_LIMIT);
        writeReg(`TIMER_BASE + `TACTL_OFS,
                 (16'd1 << `TA_RUN) | (16'd1 << `TA_CLEAR) | (16'd1 << `TA_CCR0_IE));
        waitVector(`VEC_TIMER_CCR0, WAIT_LIMIT);
        @(posedge SysClock);
        irqAck <= 1'b1;
        @(posedge SysClock);
        irqAck <= 1'b0;
        waitVector(`VEC_PORT, WAIT_LIMIT);
        readReg(`TIMER_BASE + `TAIFG_OFS, value);
        checkValue("CCR0 flag", 16'd0, 16'(value[0]));
        // flag returns on the next wrap
        waitVector(`VEC_TIMER_CCR0, 400);

        endRun();
    end

endmodule

/* msp430Periph_asserts.sv */
`timescale 1ns/1ps

module msp430Periph_assertions (
    input logic                        SysClock,
    input logic                        reset,
    input logic                        awready,
    input logic                        wready,
    input logic                        arready,
    input logic                        bvalid,
    input logic                        bready,
    input logic                        rvalid,
    input logic                        rready,
    input msp430PeriphPkg::regData     rdata,
    input msp430PeriphPkg::portBits    pinOutEnable,
    input logic                        irq,
    input msp430PeriphPkg::irqVector   irqVector,
    input logic                        irqAck,
    input logic                        ccr0Irq,
    input logic                        ccrIrq,
    input logic                        portIrq
);

    int failures;

    // write response held until accepted
    bvalidHold: assert property (@(posedge SysClock) disable iff (reset)
        bvalid && !bready |=> bvalid)
        else begin
            failures++;
            $error("bvalid dropped before bready");
        end

    // read response and its data held until accepted
    rvalidHold: assert property (@(posedge SysClock) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            failures++;
            $error("rvalid or rdata changed before rready");
        end

    // outputs quiet right after a reset cycle
    resetQuiet: assert property (@(posedge SysClock)
        reset |=> !irq && pinOutEnable == '0 && !bvalid && !rvalid
                  && !awready && !wready && !arready)
        else begin
            failures++;
            $error("outputs not idle after reset");
        end

    // vector only moves when the request levels move
    vectorStable: assert property (@(posedge SysClock) disable iff (reset)
        irq && !irqAck && $stable({ccr0Irq, ccrIrq, portIrq}) |=> $stable(irqVector))
        else begin
            failures++;
            $error("irqVector changed while irq was high");
        end

endmodule

/* msp430Periph.sv */
`timescale 1ns/1ps
`include "msp430Periph_macros.svh"

module msp430Periph (
    input  logic                        SysClock,
    input  logic                        reset,

    input  msp430PeriphPkg::regAddr     awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  msp430PeriphPkg::regData     wdata,
    input  logic [`DATA_WIDTH/8-1:0]    wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  msp430PeriphPkg::regAddr     araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output msp430PeriphPkg::regData     rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,

    input  msp430PeriphPkg::portBits    pinIn,
    output msp430PeriphPkg::portBits    pinOut,
    output msp430PeriphPkg::portBits    pinOutEnable,

    output logic                        irq,
    output msp430PeriphPkg::irqVector   irqVector,
    input  logic                        irqAck
);

    msp430PeriphPkg::regAddr regAddr;
    msp430PeriphPkg::regData regWdata;
    msp430PeriphPkg::regData regRdata;
    msp430PeriphPkg::regData portRdata;
    msp430PeriphPkg::regData timerRdata;
    logic                    regWrite;

    logic timerOut1;
    logic timerOut2;
    logic ccr0Irq;
    logic ccrIrq;
    logic portIrq;
    logic ccr0Clear;

    // unselected peripherals return zero
    assign regRdata = portRdata | timerRdata;

    axiLiteRegBridge bridge (
        .SysClock(SysClock), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .regAddr(regAddr), .regWdata(regWdata), .regWrite(regWrite),
        .regRead(), .regRdata(regRdata)
    );

    digitalPort port (
        .SysClock(SysClock), .reset(reset),
        .regAddr(regAddr), .regWdata(regWdata), .regWrite(regWrite),
        .regRdata(portRdata),
        .pinIn(pinIn), .pinOut(pinOut), .pinOutEnable(pinOutEnable),
        .timerOut1(timerOut1), .timerOut2(timerOut2),
        .portIrq(portIrq)
    );

    timerA timer (
        .SysClock(SysClock), .reset(reset),
        .regAddr(regAddr), .regWdata(regWdata), .regWrite(regWrite),
        .regRdata(timerRdata),
        .ccr0Clear(ccr0Clear),
        .timerOut1(timerOut1), .timerOut2(timerOut2),
        .ccr0Irq(ccr0Irq), .ccrIrq(ccrIrq)
    );

    interruptUnit intUnit (
        .SysClock(SysClock), .reset(reset),
        .ccr0Irq(ccr0Irq), .ccrIrq(ccrIrq), .portIrq(portIrq),
        .irqAck(irqAck),
        .irq(irq), .irqVector(irqVector), .ccr0Clear(ccr0Clear)
    );

endmodule

/* interruptUnit.sv */
`timescale 1ns/1ps
`include "msp430Periph_macros.svh"

module interruptUnit (
    input  logic                        SysClock,
    input  logic                        reset,
    input  logic                        ccr0Irq,
    input  logic                        ccrIrq,
    input  logic                        portIrq,
    input  logic                        irqAck,
    output logic                        irq,
    output msp430PeriphPkg::irqVector   irqVector,
    output logic                        ccr0Clear
);

    msp430PeriphPkg::irqVector nextVector;
    logic                      anyPending;

    assign anyPending = ccr0Irq | ccrIrq | portIrq;

    // fixed priority, CCR0 highest
    always_comb begin
        if (ccr0Irq) begin
            nextVector = `VEC_TIMER_CCR0;
        end else if (ccrIrq) begin
            nextVector = `VEC_TIMER_CCR;
        end else if (portIrq) begin
            nextVector = `VEC_PORT;
        end else begin
            nextVector = '0;
        end
    end

    always_ff @(posedge SysClock) begin
        if (reset) begin
            irq       <= 1'b0;
            irqVector <= '0;
        end else begin
            irq       <= anyPending;
            irqVector <= nextVector;
        end
    end

    // only the CCR0 source is cleared by acknowledge
    assign ccr0Clear = irqAck & irq & (irqVector == `VEC_TIMER_CCR0);

endmodule

/* timerA.sv */
`timescale 1ns/1ps
`include "msp430Periph_macros.svh"

module timerA (
    input  logic                      SysClock,
    input  logic                      reset,
    input  msp430PeriphPkg::regAddr   regAddr,
    input  msp430PeriphPkg::regData   regWdata,
    input  logic                      regWrite,
    output msp430PeriphPkg::regData   regRdata,
    input  logic                      ccr0Clear,
    output logic                      timerOut1,
    output logic                      timerOut2,
    output logic                      ccr0Irq,
    output logic                      ccrIrq
);

    msp430PeriphPkg::regData tactl;
    msp430PeriphPkg::regData tar;
    msp430PeriphPkg::regData taccr0;
    msp430PeriphPkg::regData taccr1;
    msp430PeriphPkg::regData taccr2;

    logic       ccr0Flag;
    logic [2:1] taifg;
    logic       running;
    logic       wrap;
    logic       clearWrite;
    logic [2:1] match;

    assign running    = tactl[`TA_RUN];
    assign wrap       = running & (tar == taccr0);
    assign clearWrite = regWrite & (regAddr == `TIMER_BASE + `TACTL_OFS)
                        & regWdata[`TA_CLEAR];
    assign match      = {running & (tar == taccr2), running & (tar == taccr1)};

    // up mode, period is TACCR0+1
    always_ff @(posedge SysClock) begin
        if (reset) begin
            tar <= '0;
        end else if (clearWrite || wrap) begin
            tar <= '0;
        end else if (running) begin
            tar <= tar + 1'b1;
        end
    end

    always_ff @(posedge SysClock) begin
        if (reset) begin
            tactl    <= '0;
            taccr0   <= '0;
            taccr1   <= '0;
            taccr2   <= '0;
            ccr0Flag <= 1'b0;
            taifg    <= '0;
        end else begin
            // a wrap on the acknowledge edge wins
            if (wrap) begin
                ccr0Flag <= 1'b1;
            end else if (ccr0Clear) begin
                ccr0Flag <= 1'b0;
            end
            taifg <= taifg | match;
            if (regWrite) begin
                case (regAddr)
                    `TIMER_BASE + `TACTL_OFS: begin
                        tactl <= regWdata;
                        // clear bit never reads back
                        tactl[`TA_CLEAR] <= 1'b0;
                    end
                    `TIMER_BASE + `TACCR0_OFS: taccr0 <= regWdata;
                    `TIMER_BASE + `TACCR1_OFS: taccr1 <= regWdata;
                    `TIMER_BASE + `TACCR2_OFS: taccr2 <= regWdata;
                    `TIMER_BASE + `TAIFG_OFS:  taifg  <= regWdata[2:1] | match;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        regRdata = '0;
        case (regAddr)
            `TIMER_BASE + `TACTL_OFS:  regRdata = tactl;
            `TIMER_BASE + `TAR_OFS:    regRdata = tar;
            `TIMER_BASE + `TACCR0_OFS: regRdata = taccr0;
            `TIMER_BASE + `TACCR1_OFS: regRdata = taccr1;
            `TIMER_BASE + `TACCR2_OFS: regRdata = taccr2;
            // bit 0 mirrors the CCR0 flag
            `TIMER_BASE + `TAIFG_OFS:  regRdata = {{(`DATA_WIDTH-3){1'b0}}, taifg, ccr0Flag};
            default: regRdata = '0;
        endcase
    end

    // pwm outputs high for the first TACCRn counts of each period
    assign timerOut1 = tar < taccr1;
    assign timerOut2 = tar < taccr2;

    assign ccr0Irq = ccr0Flag & tactl[`TA_CCR0_IE];
    assign ccrIrq  = (|taifg) & tactl[`TA_CCR_IE];

endmodule

/* digitalPort.sv */
`timescale 1ns/1ps
`include "msp430Periph_macros.svh"

module digitalPort (
    input  logic                      SysClock,
    input  logic                      reset,
    input  msp430PeriphPkg::regAddr   regAddr,
    input  msp430PeriphPkg::regData   regWdata,
    input  logic                      regWrite,
    output msp430PeriphPkg::regData   regRdata,
    input  msp430PeriphPkg::portBits  pinIn,
    output msp430PeriphPkg::portBits  pinOut,
    output msp430PeriphPkg::portBits  pinOutEnable,
    input  logic                      timerOut1,
    input  logic                      timerOut2,
    output logic                      portIrq
);

    msp430PeriphPkg::portBits pout;
    msp430PeriphPkg::portBits pdir;
    msp430PeriphPkg::portBits psel;
    msp430PeriphPkg::portBits pie;
    msp430PeriphPkg::portBits pifg;

    msp430PeriphPkg::portBits pinMeta;
    msp430PeriphPkg::portBits pinSync;
    msp430PeriphPkg::portBits pinLast;
    msp430PeriphPkg::portBits pinRise;

    msp430PeriphPkg::portBits periphOut;

    // two-flop synchroniser plus one stage for edge detection
    always_ff @(posedge SysClock) begin
        if (reset) begin
            pinMeta <= '0;
            pinSync <= '0;
            pinLast <= '0;
        end else begin
            pinMeta <= pinIn;
            pinSync <= pinMeta;
            pinLast <= pinSync;
        end
    end

    assign pinRise = pinSync & ~pinLast;

    always_ff @(posedge SysClock) begin
        if (reset) begin
            pout <= '0;
            pdir <= '0;
            psel <= '0;
            pie  <= '0;
            pifg <= '0;
        end else begin
            // new edges are never lost to a write in the same cycle
            pifg <= pifg | (pinRise & pie);
            if (regWrite) begin
                case (regAddr)
                    `PORT_BASE + `POUT_OFS: pout <= regWdata;
                    `PORT_BASE + `PDIR_OFS: pdir <= regWdata;
                    `PORT_BASE + `PSEL_OFS: psel <= regWdata;
                    `PORT_BASE + `PIE_OFS:  pie  <= regWdata;
                    `PORT_BASE + `PIFG_OFS: pifg <= regWdata | (pinRise & pie);
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        regRdata = '0;
        case (regAddr)
            `PORT_BASE + `PIN_OFS:  regRdata = pinSync;
            `PORT_BASE + `POUT_OFS: regRdata = pout;
            `PORT_BASE + `PDIR_OFS: regRdata = pdir;
            `PORT_BASE + `PSEL_OFS: regRdata = psel;
            `PORT_BASE + `PIE_OFS:  regRdata = pie;
            `PORT_BASE + `PIFG_OFS: regRdata = pifg;
            default: regRdata = '0;
        endcase
    end

    // only pins 0 and 1 have a peripheral function
    assign periphOut = {{(`PORT_WIDTH-2){1'b0}}, timerOut2, timerOut1};

    // per-pin function select
    always_comb begin
        for (int i = 0; i < `PORT_WIDTH; i++) begin
            if (psel[i]) begin
                pinOut[i]       = periphOut[i];
                pinOutEnable[i] = (i < 2);
            end else begin
                pinOut[i]       = pout[i];
                pinOutEnable[i] = pdir[i];
            end
        end
    end

    assign portIrq = |pifg;

endmodule

/* axiLiteRegBridge.sv */
`timescale 1ns/1ps
`include "msp430Periph_macros.svh"

module axiLiteRegBridge (
    input  logic                      SysClock,
    input  logic                      reset,

    input  msp430PeriphPkg::regAddr   awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  msp430PeriphPkg::regData   wdata,
    input  logic [`DATA_WIDTH/8-1:0]  wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,

    input  msp430PeriphPkg::regAddr   araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output msp430PeriphPkg::regData   rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,

    output msp430PeriphPkg::regAddr   regAddr,
    output msp430PeriphPkg::regData   regWdata,
    output logic                      regWrite,
    output logic                      regRead,
    input  msp430PeriphPkg::regData   regRdata
);

    logic writeAccept;
    logic readAccept;

    // address and data must arrive together, one write response outstanding
    assign writeAccept = awvalid & wvalid & ~bvalid;

    // a write in the same cycle pushes the read to the next one
    assign readAccept = arvalid & ~rvalid & ~writeAccept;

    assign awready = writeAccept;
    assign wready  = writeAccept;
    assign arready = readAccept;

    // register strobe bus
    assign regWrite = writeAccept;
    assign regRead  = readAccept;
    assign regAddr  = writeAccept ? awaddr : araddr;
    assign regWdata = wdata;

    // always OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    always_ff @(posedge SysClock) begin
        if (reset) begin
            bvalid <= 1'b0;
        end else if (writeAccept) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge SysClock) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (readAccept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // captured at the accept edge, held until the next read
    always_ff @(posedge SysClock) begin
        if (readAccept) begin
            rdata <= regRdata;
        end
    end

endmodule

/* msp430PeriphPkg.sv */
`include "msp430Periph_macros.svh"

package msp430PeriphPkg;

    // byte address on the internal register bus
    typedef logic [`ADDR_WIDTH-1:0] regAddr;

    // register and bus data word
    typedef logic [`DATA_WIDTH-1:0] regData;

    // one bit per port pin
    typedef logic [`PORT_WIDTH-1:0] portBits;

    // interrupt vector number
    typedef logic [`VEC_WIDTH-1:0] irqVector;

endpackage

/* msp430Periph_macros.svh */
`ifndef MSP430PERIPH_MACROS_SVH
`define MSP430PERIPH_MACROS_SVH

// bus and port widths
`define DATA_WIDTH 16
`define ADDR_WIDTH 16
`define PORT_WIDTH 16
`define VEC_WIDTH 6

// digital port map
`define PORT_BASE 16'h0200
`define PIN_OFS 16'd0
`define POUT_OFS 16'd2
`define PDIR_OFS 16'd4
`define PSEL_OFS 16'd6
`define PIE_OFS 16'd8
`define PIFG_OFS 16'd10

// timer map
`define TIMER_BASE 16'h0340
`define TACTL_OFS 16'd0
`define TAR_OFS 16'd2
`define TACCR0_OFS 16'd4
`define TACCR1_OFS 16'd6
`define TACCR2_OFS 16'd8
`define TAIFG_OFS 16'd10

// TACTL bit positions
`define TA_RUN 0
`define TA_CLEAR 1
`define TA_CCR0_IE 2
`define TA_CCR_IE 3

// interrupt vector numbers
`define VEC_TIMER_CCR0 6'd52
`define VEC_TIMER_CCR 6'd51
`define VEC_PORT 6'd45

`endif
